// File: Bender.yml
package:
  name: clk_div

sources:
  - clk_div_pkg.sv
  - div_cfg_if.sv
  - div_ctrl.sv
  - div_even.sv
  - div_odd.sv
  - clk_div_top.sv
  - target: test
    files:
      - tb_clk_div.sv

// File: clk_div_pkg.sv
package clk_div_pkg;

	// width of the division factor
	localparam int DIV_W = 8;

	// division factor as given on the top port
	// 0 and 1 both mean divide by one
	typedef logic [DIV_W-1:0] divisor_t;

	// divider selection held by the control FSM
	typedef enum logic [1:0]
	{
		MODE_OFF    = 2'd0,	// disabled, output held low
		MODE_BYPASS = 2'd1,	// factor 0 or 1, clk passes through
		MODE_EVEN   = 2'd2,	// rising-edge divider
		MODE_ODD    = 2'd3	// dual-edge divider
	} div_mode_t;

endpackage

// File: clk_div_top.sv
module clk_div_top
(
	input  logic clk,			// system clock
	input  logic reset,			// async, active high
	input  logic enable,			// run the divider
	input  clk_div_pkg::divisor_t divisor,	// division factor
	output logic clk_out			// divided clock
);

	logic even_clk;		// even divider output
	logic odd_clk;		// odd divider output

	div_cfg_if cfg ();	// control to datapath bundle

	// mode FSM, restart pulse and output mux
	div_ctrl u_ctrl
	(
		.clk        (clk),
		.reset      (reset),
		.enable     (enable),
		.divisor_in (divisor),
		.even_clk   (even_clk),
		.odd_clk    (odd_clk),
		.clk_out    (clk_out),
		.cfg        (cfg.ctrl)
	);

	div_even u_even
	(
		.clk      (clk),
		.reset    (reset),
		.cfg      (cfg.even),
		.even_clk (even_clk)
	);

	div_odd u_odd
	(
		.clk     (clk),
		.reset   (reset),
		.cfg     (cfg.odd),
		.odd_clk (odd_clk)
	);

endmodule

// File: div_cfg_if.sv
interface div_cfg_if;

	clk_div_pkg::divisor_t divisor;	// registered factor from control
	logic restart;			// one-cycle reload pulse
	logic even_en;			// even divider may count
	logic odd_en;			// odd divider may count

	// control side drives everything
	modport ctrl
	(
		output divisor,
		output restart,
		output even_en,
		output odd_en
	);

	// even divider only sees its own enable
	modport even
	(
		input divisor,
		input restart,
		input even_en
	);

	// odd divider only sees its own enable
	modport odd
	(
		input divisor,
		input restart,
		input odd_en
	);

endinterface

// File: div_ctrl.sv
module div_ctrl
(
	input  logic clk,			// system clock
	input  logic reset,			// async, active high
	input  logic enable,			// divider enable level
	input  clk_div_pkg::divisor_t divisor_in,	// factor from the port
	input  logic even_clk,			// output of the even divider
	input  logic odd_clk,			// output of the odd divider
	output logic clk_out,			// selected divided clock
	div_cfg_if.ctrl cfg			// settings to both dividers
);

	clk_div_pkg::div_mode_t mode;		// current FSM state
	clk_div_pkg::div_mode_t mode_next;	// state from enable and factor
	clk_div_pkg::divisor_t divisor_q;	// last sampled factor
	logic enable_q;				// last sampled enable
	logic restart_q;			// reload pulse register
	logic factor_changed;			// factor differs from last sample
	logic enable_rose;			// enable went high this cycle

	// mode decision from the live port values
	always_comb
	begin
		if (!enable)
		begin
			mode_next = clk_div_pkg::MODE_OFF;	// frozen, output low
		end
		else if (divisor_in <= clk_div_pkg::divisor_t'(1))
		begin
			mode_next = clk_div_pkg::MODE_BYPASS;	// divide by one
		end
		else if (divisor_in[0])
		begin
			mode_next = clk_div_pkg::MODE_ODD;	// low bit set
		end
		else
		begin
			mode_next = clk_div_pkg::MODE_EVEN;
		end
	end

	assign factor_changed = (divisor_in != divisor_q);
	assign enable_rose = enable && !enable_q;

	// state, factor copy and restart pulse all move on the same edge,
	// so the dividers see the new factor together with restart
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			mode <= clk_div_pkg::MODE_OFF;
			divisor_q <= '0;
			enable_q <= 1'b0;
			restart_q <= 1'b0;
		end
		else
		begin
			mode <= mode_next;
			divisor_q <= divisor_in;	// previous value for the change test
			enable_q <= enable;
			restart_q <= enable && (factor_changed || enable_rose);	// one cycle only
		end
	end

	assign cfg.divisor = divisor_q;
	assign cfg.restart = restart_q;
	assign cfg.even_en = (mode == clk_div_pkg::MODE_EVEN);	// only the active divider runs
	assign cfg.odd_en = (mode == clk_div_pkg::MODE_ODD);

	// output select, bypass passes clk straight through
	always_comb
	begin
		case (mode)
			clk_div_pkg::MODE_BYPASS:
			begin
				clk_out = clk;
			end
			clk_div_pkg::MODE_EVEN:
			begin
				clk_out = even_clk;
			end
			clk_div_pkg::MODE_ODD:
			begin
				clk_out = odd_clk;
			end
			default:
			begin
				clk_out = 1'b0;		// MODE_OFF
			end
		endcase
	end

endmodule

// File: div_even.sv
module div_even
(
	input  logic clk,		// system clock
	input  logic reset,		// async, active high
	div_cfg_if.even cfg,		// factor, restart, enable
	output logic even_clk		// divided clock, 50% duty
);

	clk_div_pkg::divisor_t half;	// half the factor, edges per level
	clk_div_pkg::divisor_t count;	// down counter
	logic out_q;			// output flop

	// even factor so the shift is exact
	assign half = {1'b0, cfg.divisor[clk_div_pkg::DIV_W-1:1]};

	// rising-edge counter, toggles every half period
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			count <= '0;
			out_q <= 1'b0;
		end
		else if (cfg.restart)
		begin
			count <= half;		// reload on new factor
			out_q <= 1'b1;		// start on a high level
		end
		else if (cfg.even_en)
		begin
			if (count == clk_div_pkg::divisor_t'(1))
			begin
				count <= half;
				out_q <= ~out_q;	// half period elapsed
			end
			else
			begin
				count <= count - 1'b1;
			end
		end
		// not enabled, counter and flop hold
	end

	assign even_clk = out_q;

endmodule

// File: div_odd.sv
module div_odd
(
	input  logic clk,		// system clock
	input  logic reset,		// async, active high
	div_cfg_if.odd cfg,		// factor, restart, enable
	output logic odd_clk		// divided clock, 50% duty
);

	clk_div_pkg::divisor_t count_pos;	// rising-edge counter
	clk_div_pkg::divisor_t count_neg;	// falling-edge counter
	clk_div_pkg::divisor_t offset;		// start delay of the falling side
	logic [clk_div_pkg::DIV_W:0] offset_sum;	// N+3 with carry bit
	logic out_pos;				// toggles every N rising edges
	logic out_neg;				// toggles every N falling edges
	logic offset_done;			// falling side may count

	// (N+3)/2 half-cycle shift puts the falling toggles midway
	// between rising toggles
	assign offset_sum = {1'b0, cfg.divisor} + 2'd3;
	assign offset_done = (offset <= clk_div_pkg::divisor_t'(1));

	// rising-edge side
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			count_pos <= '0;
			out_pos <= 1'b0;
		end
		else if (cfg.restart)
		begin
			count_pos <= cfg.divisor;	// reload with full factor
			out_pos <= 1'b1;
		end
		else if (cfg.odd_en)
		begin
			if (count_pos == clk_div_pkg::divisor_t'(1))
			begin
				count_pos <= cfg.divisor;
				out_pos <= ~out_pos;
			end
			else
			begin
				count_pos <= count_pos - 1'b1;
			end
		end
	end

	// falling-edge side, samples restart mid-cycle
	always_ff @(negedge clk or posedge reset)
	begin
		if (reset)
		begin
			count_neg <= '0;
			offset <= '0;
			out_neg <= 1'b0;
		end
		else if (cfg.restart)
		begin
			count_neg <= cfg.divisor;
			offset <= offset_sum[clk_div_pkg::DIV_W:1];	// divide by two
			out_neg <= 1'b1;
		end
		else if (cfg.odd_en && offset_done)
		begin
			if (count_neg == clk_div_pkg::divisor_t'(1))
			begin
				count_neg <= cfg.divisor;
				out_neg <= ~out_neg;
			end
			else
			begin
				count_neg <= count_neg - 1'b1;
			end
		end
		else if (cfg.odd_en)
		begin
			offset <= offset - 1'b1;	// still waiting out the shift
		end
	end

	// two period-2N waves shifted by N/2 cycles, xor gives period N
	assign odd_clk = out_pos ^ out_neg;

endmodule

// File: filelist.f
clk_div_pkg.sv
div_cfg_if.sv
div_ctrl.sv
div_even.sv
div_odd.sv
clk_div_top.sv
tb_clk_div.sv

// File: tb_clk_div.sv
module tb_clk_div;

	timeunit 1ns;
	timeprecision 100ps;

	// each setting costs about (2+6)*N cycles plus settling
	// sum of N over all settings is under 200, so about 1600 cycles, doubled for margin
	localparam int MAX_CYCLES = 4000;
	localparam real HALF_CLK = 2.0;		// ns, one clk level
	localparam real TOL = 0.1;		// ns, timing tolerance

	logic clk;
	logic reset;
	logic enable;
	clk_div_pkg::divisor_t divisor;
	logic clk_out;

	int errors;		// failed checks
	int checks;		// checks done
	int cycle_count;	// rising clk edges since start
	int seed;		// random factor source

	clk_div_top u_dut
	(
		.clk     (clk),
		.reset   (reset),
		.enable  (enable),
		.divisor (divisor),
		.clk_out (clk_out)
	);

	// 4 ns clock
	always #2 clk = ~clk;

	// run limit
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("timeout after %0d clock cycles, %0d errors in %0d checks",
				cycle_count, errors, checks);
			$display("TEST FAILED");
			$finish;
		end
	end

	// new enable and factor, 1 ns after the rising edge
	task automatic drive_setting(input logic en, input int factor);
		@(posedge clk);
		#1;
		enable = en;
		divisor = clk_div_pkg::divisor_t'(factor);
	endtask

	// waits for clk_out to change to level, sampled just after each clk edge
	// t_edge is the time of the clk edge that moved clk_out
	task automatic wait_clk_out_edge(input logic level, input int max_half_cycles,
		output real t_edge, output bit found);
		logic prev;
		int n;
		prev = clk_out;
		found = 1'b0;
		t_edge = 0.0;
		n = 0;
		while (!found && n < max_half_cycles)
		begin
			@(clk);			// clk_out only moves on clk edges
			t_edge = $realtime;
			#0.2;			// let the NBA region settle
			if (clk_out !== prev && clk_out === level)
			begin
				found = 1'b1;
			end
			prev = clk_out;
			n++;
		end
	endtask

	// missing edge report
	task automatic expect_edge(input bit found, input string dir, input int factor,
		input int window);
		checks++;
		assert (found)
		else
		begin
			$display("clk_out did not %s within %0d clock half cycles at factor %0d (t=%0t)",
				dir, window, factor, $realtime);
			errors++;
		end
	endtask

	// one high or low time against N clk half periods
	task automatic compare_time(input string what, input int factor, input real measured);
		real expected;
		real diff;
		int exp_units;
		int got_units;
		expected = factor * HALF_CLK;
		diff = measured - expected;
		exp_units = int'(expected * 10.0);	// units of 100 ps
		got_units = int'(measured * 10.0);
		checks++;
		assert (diff <= TOL && diff >= -TOL)
		else
		begin
			$display("ERROR clk_out %s time, factor %0d: expected 0x%0h measured 0x%0h (100 ps)",
				what, factor, exp_units, got_units);
			errors++;
		end
	endtask

	// clk_out level at this moment
	task automatic compare_level(input logic expected);
		checks++;
		assert (clk_out === expected)
		else
		begin
			$display("ERROR clk_out: expected 0x%0h measured 0x%0h (t=%0t)",
				expected, clk_out, $realtime);
			errors++;
		end
	endtask

	// skip start-up, then three high and three low times
	task automatic measure_timing(input int factor);
		real t_rise;
		real t_fall;
		real t_next;
		bit found;
		int k;
		int window;
		window = factor + 4;			// one level plus slack
		repeat (2 * factor + 4) @(posedge clk);	// covers the first two output periods
		#0.2;
		wait_clk_out_edge(1'b1, 2 * window, t_rise, found);
		expect_edge(found, "rise", factor, 2 * window);
		if (!found)
		begin
			return;
		end
		for (k = 0; k < 3; k++)
		begin
			wait_clk_out_edge(1'b0, window, t_fall, found);
			expect_edge(found, "fall", factor, window);
			if (!found)
			begin
				return;
			end
			compare_time("high", factor, t_fall - t_rise);
			wait_clk_out_edge(1'b1, window, t_next, found);
			expect_edge(found, "rise", factor, window);
			if (!found)
			begin
				return;
			end
			compare_time("low", factor, t_next - t_fall);
			t_rise = t_next;
		end
	endtask

	// clk_out must mirror clk, sampled 1 ns after both edges
	task automatic sample_against_clk(input int cycles);
		repeat (cycles)
		begin
			@(posedge clk);
			#1;
			compare_level(1'b1);		// clk is high here
			@(negedge clk);
			#1;
			compare_level(1'b0);
		end
	endtask

	task automatic even_factors();
		int factors[4];
		int i;
		factors = '{2, 4, 6, 10};
		$display("even division");
		for (i = 0; i < 4; i++)
		begin
			drive_setting(1'b1, factors[i]);
			measure_timing(factors[i]);
		end
	endtask

	task automatic odd_factors();
		int factors[4];
		int i;
		factors = '{3, 5, 7, 9};
		$display("odd division");
		for (i = 0; i < 4; i++)
		begin
			drive_setting(1'b1, factors[i]);
			measure_timing(factors[i]);	// half-cycle levels via falling edge
		end
	endtask

	task automatic bypass_passthrough();
		$display("bypass");
		drive_setting(1'b1, 0);
		repeat (3) @(posedge clk);		// mode update
		sample_against_clk(8);
		drive_setting(1'b1, 1);
		repeat (3) @(posedge clk);
		sample_against_clk(8);
	endtask

	// factor changes while enabled, restart must pick up each one
	task automatic factor_change_live();
		$display("factor change while running");
		drive_setting(1'b1, 4);
		measure_timing(4);
		drive_setting(1'b1, 7);		// even to odd
		measure_timing(7);
		drive_setting(1'b1, 6);		// odd back to even
		measure_timing(6);
	endtask

	task automatic disable_and_resume();
		int k;
		$display("disable and resume");
		drive_setting(1'b1, 5);
		measure_timing(5);
		drive_setting(1'b0, 5);
		@(posedge clk);			// mode goes off here
		for (k = 0; k < 20; k++)
		begin
			#1;
			compare_level(1'b0);
			@(negedge clk);
			#1;
			compare_level(1'b0);
			@(posedge clk);
		end
		drive_setting(1'b1, 5);		// enable rise restarts
		measure_timing(5);
	endtask

	task automatic random_factors();
		int k;
		int r;
		int factor;
		$display("random factors");
		for (k = 0; k < 6; k++)
		begin
			r = $random(seed);
			factor = 2 + ((r & 32'h7fff_ffff) % 14);	// 2 to 15
			$display("  factor %0d", factor);
			drive_setting(1'b1, factor);
			measure_timing(factor);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		enable = 1'b0;
		divisor = '0;
		errors = 0;
		checks = 0;
		cycle_count = 0;
		seed = 53922;

		repeat (8) @(posedge clk);
		#1;
		compare_level(1'b0);		// low in reset
		reset = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		compare_level(1'b0);		// still off, enable low

		even_factors();
		odd_factors();
		bypass_passthrough();
		factor_change_live();
		disable_and_resume();
		random_factors();

		repeat (2) @(posedge clk);
		$display("%0d errors in %0d checks, %0d cycles", errors, checks, cycle_count);
		if (errors == 0)
		begin
			$display("TEST OK");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
